// ==== rtl/axiLitePkg.sv ====
package axiLitePkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;  // one per byte lane

  typedef logic [ADDR_W-1:0] addrT;
  typedef logic [DATA_W-1:0] dataT;
  typedef logic [STRB_W-1:0] strbT;
  typedef logic [1:0]        respT;

  // only two of the four AXI codes are ever returned here
  localparam respT RESP_OKAY   = 2'b00;
  localparam respT RESP_SLVERR = 2'b10;

  ////////////////////////////////////////////////////////////
  // write channels
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    addrT awaddr;
    logic awvalid;
  } awChanT;

  typedef struct packed {
    dataT wdata;
    strbT wstrb;
    logic wvalid;
  } wChanT;

  typedef struct packed {
    respT bresp;
    logic bvalid;
  } bChanT;

endpackage

// ==== rtl/writeAgentPkg.sv ====
package writeAgentPkg;

  // one requested write, from outside
  typedef struct packed {
    axiLitePkg::addrT addr;
    axiLitePkg::dataT data;
    axiLitePkg::strbT strb;
  } writeCmdT;

  // one finished write, as seen by the monitor
  typedef struct packed {
    axiLitePkg::addrT addr;
    axiLitePkg::respT resp;
  } writeStatusT;

  typedef enum logic [1:0] {
    IDLE,
    SEND,      // aw and/or w still outstanding
    WAITRESP
  } drvStateT;

  typedef logic [15:0] countT;

endpackage

// ==== rtl/writeDriver.sv ====
`timescale 1ns/10ps

module writeDriver (
  input  logic                   aclk,
  input  logic                   rstN,
  input  logic                   start,
  input  writeAgentPkg::writeCmdT cmd,
  output axiLitePkg::awChanT     aw,
  input  logic                   awready,
  output axiLitePkg::wChanT      w,
  input  logic                   wready,
  input  axiLitePkg::bChanT      b,
  output logic                   bready,
  output logic                   busy
);

  writeAgentPkg::drvStateT state;

  logic awDone;  // aw finished or finishing this cycle
  logic wDone;

  assign awDone = !aw.awvalid || awready;
  assign wDone  = !w.wvalid || wready;

  ////////////////////////////////////////////////////////////
  // channel FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk or negedge rstN) begin
    if (!rstN) begin
      state <= writeAgentPkg::IDLE;
      aw    <= '0;
      w     <= '0;
    end else begin
      case (state)
        writeAgentPkg::IDLE: begin
          // a start while busy never reaches here, so it is simply dropped
          if (start) begin
            aw.awaddr  <= cmd.addr;
            aw.awvalid <= 1'b1;
            w.wdata    <= cmd.data;
            w.wstrb    <= cmd.strb;
            w.wvalid   <= 1'b1;
            state      <= writeAgentPkg::SEND;
          end
        end

        writeAgentPkg::SEND: begin
          if (aw.awvalid && awready) begin
            aw.awvalid <= 1'b0;
          end
          if (w.wvalid && wready) begin
            w.wvalid <= 1'b0;
          end
          if (awDone && wDone) begin
            state <= writeAgentPkg::WAITRESP;
          end
        end

        writeAgentPkg::WAITRESP: begin
          if (b.bvalid) begin  // bready is high here
            state <= writeAgentPkg::IDLE;
          end
        end

        default: begin
          state <= writeAgentPkg::IDLE;
        end
      endcase
    end
  end

  assign bready = (state == writeAgentPkg::WAITRESP);
  assign busy   = (state != writeAgentPkg::IDLE);

endmodule

// ==== rtl/writeMonitor.sv ====
`timescale 1ns/10ps

module writeMonitor (
  input  logic                      aclk,
  input  logic                      rstN,
  input  axiLitePkg::awChanT        aw,
  input  logic                      awready,
  input  axiLitePkg::bChanT         b,
  input  logic                      bready,
  output logic                      done,
  output writeAgentPkg::writeStatusT status,
  output writeAgentPkg::countT      writeCount,
  output writeAgentPkg::countT      errorCount
);

  axiLitePkg::addrT addrQ;  // address of the write in flight

  logic awHs;
  logic bHs;

  assign awHs = aw.awvalid && awready;
  assign bHs  = b.bvalid && bready;

  ////////////////////////////////////////////////////////////
  // address capture
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk or negedge rstN) begin
    if (!rstN) begin
      addrQ <= '0;
    end else if (awHs) begin
      addrQ <= aw.awaddr;
    end
  end

  ////////////////////////////////////////////////////////////
  // completion report
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk or negedge rstN) begin
    if (!rstN) begin
      done       <= 1'b0;
      status     <= '0;
      writeCount <= '0;
      errorCount <= '0;
    end else begin
      done <= bHs;  // one cycle after B
      if (bHs) begin
        status.addr <= addrQ;
        status.resp <= b.bresp;
        writeCount  <= writeCount + 1'b1;
        if (b.bresp != axiLitePkg::RESP_OKAY) begin
          errorCount <= errorCount + 1'b1;
        end
      end
    end
  end

endmodule

// ==== rtl/writeMasterAgent.sv ====
`timescale 1ns/10ps

module writeMasterAgent (
  input  logic                      aclk,
  input  logic                      rstN,
  input  logic                      start,
  input  writeAgentPkg::writeCmdT    cmd,
  output logic                      busy,
  output logic                      done,
  output writeAgentPkg::writeStatusT status,
  output writeAgentPkg::countT      writeCount,
  output writeAgentPkg::countT      errorCount,
  output axiLitePkg::awChanT        aw,
  input  logic                      awready,
  output axiLitePkg::wChanT         w,
  input  logic                      wready,
  input  axiLitePkg::bChanT         b,
  output logic                      bready
);

  // driver owns the channel outputs
  writeDriver driver (
    .aclk    (aclk),
    .rstN    (rstN),
    .start   (start),
    .cmd     (cmd),
    .aw      (aw),
    .awready (awready),
    .w       (w),
    .wready  (wready),
    .b       (b),
    .bready  (bready),
    .busy    (busy)
  );

  // monitor taps the same wires, read only
  writeMonitor monitor (
    .aclk       (aclk),
    .rstN       (rstN),
    .aw         (aw),
    .awready    (awready),
    .b          (b),
    .bready     (bready),
    .done       (done),
    .status     (status),
    .writeCount (writeCount),
    .errorCount (errorCount)
  );

endmodule

// ==== rtl/regFileSlave.sv ====
`timescale 1ns/10ps

module regFileSlave #(
  parameter int NUM_REGS   = 16,  // at least 2
  parameter int RESP_DELAY = 2    // at least 1
) (
  input  logic                       aclk,
  input  logic                       rstN,
  input  axiLitePkg::awChanT         aw,
  output logic                       awready,
  input  axiLitePkg::wChanT          w,
  output logic                       wready,
  output axiLitePkg::bChanT          b,
  input  logic                       bready,
  input  logic [$clog2(NUM_REGS)-1:0] regIdx,
  output axiLitePkg::dataT           regData
);

  localparam int IDX_W = $clog2(NUM_REGS);
  localparam int CNT_W = $clog2(RESP_DELAY + 1);

  axiLitePkg::dataT regs [NUM_REGS];

  logic             readyQ;       // shared by awready and wready
  logic             respPending;  // set at acceptance, cleared at B
  logic             accept;
  logic             inRange;
  logic [IDX_W-1:0] wordIdx;
  logic [CNT_W-1:0] delayCnt;

  assign inRange = (aw.awaddr[axiLitePkg::ADDR_W-1:2] < NUM_REGS);
  assign wordIdx = aw.awaddr[2 +: IDX_W];
  assign accept  = readyQ && aw.awvalid && w.wvalid;

  ////////////////////////////////////////////////////////////
  // AW/W acceptance, one-cycle ready
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk or negedge rstN) begin
    if (!rstN) begin
      readyQ <= 1'b0;
    end else begin
      readyQ <= aw.awvalid && w.wvalid && !readyQ && !respPending;
    end
  end

  assign awready = readyQ;
  assign wready  = readyQ;

  // strobe-merged write, nothing for out of range
  always_ff @(posedge aclk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (accept && inRange) begin
      for (int lane = 0; lane < axiLitePkg::STRB_W; lane++) begin
        if (w.wstrb[lane]) begin
          regs[wordIdx][8*lane +: 8] <= w.wdata[8*lane +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // delayed B response
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk or negedge rstN) begin
    if (!rstN) begin
      respPending <= 1'b0;
      delayCnt    <= '0;
      b           <= '0;
    end else if (accept) begin
      respPending <= 1'b1;
      delayCnt    <= CNT_W'(RESP_DELAY);
      b.bresp     <= inRange ? axiLitePkg::RESP_OKAY : axiLitePkg::RESP_SLVERR;
    end else if (b.bvalid) begin
      if (bready) begin  // hold until taken
        b.bvalid    <= 1'b0;
        respPending <= 1'b0;
      end
    end else if (respPending) begin
      if (delayCnt == CNT_W'(1)) begin
        b.bvalid <= 1'b1;
      end
      delayCnt <= delayCnt - 1'b1;
    end
  end

  // readback port for system use
  assign regData = (regIdx < NUM_REGS) ? regs[regIdx] : '0;

endmodule

// ==== rtl/axiLiteWriteTop.sv ====
`timescale 1ns/10ps

module axiLiteWriteTop #(
  parameter int NUM_REGS   = 16,
  parameter int RESP_DELAY = 2
) (
  input  logic                       aclk,
  input  logic                       rstN,
  input  logic                       start,
  input  writeAgentPkg::writeCmdT     cmd,
  input  logic [$clog2(NUM_REGS)-1:0] regIdx,
  output logic                       busy,
  output logic                       done,
  output writeAgentPkg::writeStatusT  status,
  output writeAgentPkg::countT       writeCount,
  output writeAgentPkg::countT       errorCount,
  output axiLitePkg::dataT           regData
);

  // AXI4-Lite write channels between agent and slave
  axiLitePkg::awChanT aw;
  axiLitePkg::wChanT  w;
  axiLitePkg::bChanT  b;
  logic               awready;
  logic               wready;
  logic               bready;

  writeMasterAgent agent (
    .aclk       (aclk),
    .rstN       (rstN),
    .start      (start),
    .cmd        (cmd),
    .busy       (busy),
    .done       (done),
    .status     (status),
    .writeCount (writeCount),
    .errorCount (errorCount),
    .aw         (aw),
    .awready    (awready),
    .w          (w),
    .wready     (wready),
    .b          (b),
    .bready     (bready)
  );

  regFileSlave #(
    .NUM_REGS   (NUM_REGS),
    .RESP_DELAY (RESP_DELAY)
  ) slave (
    .aclk    (aclk),
    .rstN    (rstN),
    .aw      (aw),
    .awready (awready),
    .w       (w),
    .wready  (wready),
    .b       (b),
    .bready  (bready),
    .regIdx  (regIdx),
    .regData (regData)
  );

endmodule

// ==== tb/axiLiteWrite_properties.sv ====
`timescale 1ns/10ps

module axiLiteWriteProperties #(
  parameter int RESP_DELAY = 2
) (
  input logic                 aclk,
  input logic                 rstN,
  input logic                 start,
  input logic                 busy,
  input logic                 done,
  input writeAgentPkg::countT writeCount,
  input writeAgentPkg::countT errorCount,
  input axiLitePkg::awChanT   aw,
  input logic                 awready,
  input axiLitePkg::wChanT    w,
  input logic                 wready,
  input axiLitePkg::bChanT    b,
  input logic                 bready
);

  int unsigned violations;  // polled from the testbench
  logic        startSeen;

  always_ff @(posedge aclk or negedge rstN) begin
    if (!rstN) begin
      startSeen <= 1'b0;
    end else if (start) begin
      startSeen <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // reset state
  ////////////////////////////////////////////////////////////
  idleAfterReset: assert property (@(posedge aclk)
    rstN && !startSeen |-> !busy && !done && writeCount == '0 && errorCount == '0
      && !aw.awvalid && !w.wvalid && !bready && !b.bvalid && !awready && !wready)
    else begin
      $error("outputs not idle after reset");
      violations++;
    end

  ////////////////////////////////////////////////////////////
  // channel handshakes
  ////////////////////////////////////////////////////////////
  awHeld: assert property (@(posedge aclk) disable iff (!rstN)
    aw.awvalid && !awready |=> aw.awvalid && $stable(aw.awaddr))
    else begin
      $error("awvalid or awaddr changed before awready");
      violations++;
    end

  wHeld: assert property (@(posedge aclk) disable iff (!rstN)
    w.wvalid && !wready |=> w.wvalid && $stable({w.wdata, w.wstrb}))
    else begin
      $error("wvalid or write data changed before wready");
      violations++;
    end

  bHeld: assert property (@(posedge aclk) disable iff (!rstN)
    b.bvalid && !bready |=> b.bvalid && $stable(b.bresp))
    else begin
      $error("bvalid dropped before bready");
      violations++;
    end

  // whole write is RESP_DELAY + 4 cycles
  doneLatency: assert property (@(posedge aclk) disable iff (!rstN)
    start && !busy |-> ##1 !done [*RESP_DELAY+3] ##1 done)
    else begin
      $error("done not seen at the expected cycle after start");
      violations++;
    end

  busyEndsWithDone: assert property (@(posedge aclk) disable iff (!rstN)
    $fell(busy) == done)
    else begin
      $error("busy fall and done pulse not in the same cycle");
      violations++;
    end

endmodule

bind axiLiteWriteTop axiLiteWriteProperties #(
  .RESP_DELAY (RESP_DELAY)
) props (
  .aclk       (aclk),
  .rstN       (rstN),
  .start      (start),
  .busy       (busy),
  .done       (done),
  .writeCount (writeCount),
  .errorCount (errorCount),
  .aw         (aw),
  .awready    (awready),
  .w          (w),
  .wready     (wready),
  .b          (b),
  .bready     (bready)
);

// ==== tb/axiLiteWriteTb.sv ====
`timescale 1ns/10ps

module axiLiteWriteTb;

  localparam int NUM_REGS   = 16;  // same as the top defaults
  localparam int RESP_DELAY = 2;
  localparam int IDX_W      = $clog2(NUM_REGS);
  localparam int NUM_CMDS   = 43;  // 3 directed + 40 random
  localparam int LIMIT      = NUM_CMDS * (RESP_DELAY + 8) + 6 * NUM_REGS + 40;

  logic                       aclk;
  logic                       rstN;
  logic                       start;
  writeAgentPkg::writeCmdT    cmd;
  logic [IDX_W-1:0]           regIdx;
  logic                       busy;
  logic                       done;
  writeAgentPkg::writeStatusT status;
  writeAgentPkg::countT       writeCount;
  writeAgentPkg::countT       errorCount;
  axiLitePkg::dataT           regData;

  axiLitePkg::dataT        model [NUM_REGS];  // reference register file
  writeAgentPkg::writeCmdT pendCmd;
  logic                    pending;
  int                      seed = 42;
  int                      checkErrors;
  int                      acceptCount;
  int                      ignoreCount;
  int                      expErrors;
  int                      testsPassed;
  int                      testsFailed;

  axiLiteWriteTop UUT (
    .aclk       (aclk),
    .rstN       (rstN),
    .start      (start),
    .cmd        (cmd),
    .regIdx     (regIdx),
    .busy       (busy),
    .done       (done),
    .status     (status),
    .writeCount (writeCount),
    .errorCount (errorCount),
    .regData    (regData)
  );

  always #4 aclk = ~aclk;

  function automatic axiLitePkg::dataT mergeLanes(input axiLitePkg::dataT old,
                                                  input writeAgentPkg::writeCmdT c);
    axiLitePkg::dataT res;
    res = old;
    for (int lane = 0; lane < 4; lane++) begin
      if (c.strb[lane]) begin
        res[8*lane +: 8] = c.data[8*lane +: 8];
      end
    end
    return res;
  endfunction

  function automatic writeAgentPkg::writeCmdT randomCmd();
    writeAgentPkg::writeCmdT c;
    int idx;
    idx    = ($random(seed) & 32'h7fff) % (NUM_REGS + 4);  // some out of range
    c.addr = axiLitePkg::addrT'(idx) << 2;
    c.data = $random(seed);
    c.strb = 4'($random(seed));
    return c;
  endfunction

  task automatic expectEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error %s got %h expected %h", name, got, exp);
      checkErrors++;
    end
  endtask

  task automatic reportTest(input string name, input bit ok);
    if (ok) begin
      testsPassed++;
      $display("%s: pass", name);
    end else begin
      testsFailed++;
      $display("%s: fail", name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // response checker, samples mid-cycle
  ////////////////////////////////////////////////////////////
  always @(negedge aclk) begin
    logic hit;
    if (rstN) begin
      if (done) begin
        if (!pending) begin
          $display("done pulsed with no write in flight");
          checkErrors++;
        end else begin
          hit = (pendCmd.addr[31:2] < NUM_REGS);
          if (hit) begin
            model[pendCmd.addr[2 +: IDX_W]] = mergeLanes(model[pendCmd.addr[2 +: IDX_W]],
                                                         pendCmd);
          end else begin
            expErrors++;
          end
          expectEq("status.addr", status.addr, pendCmd.addr);
          expectEq("status.resp", status.resp,
                   hit ? axiLitePkg::RESP_OKAY : axiLitePkg::RESP_SLVERR);
          expectEq("writeCount", writeCount, acceptCount);
          expectEq("errorCount", errorCount, expErrors);
          expectEq("regData", regData, model[regIdx]);
        end
        pending = 1'b0;
      end
      if (start) begin  // taken at the next edge only when idle
        if (busy) begin
          ignoreCount++;
        end else begin
          pendCmd = cmd;
          pending = 1'b1;
          acceptCount++;
        end
      end
    end
  end

  task automatic pulseStart(input writeAgentPkg::writeCmdT c);
    @(posedge aclk);
    start  <= 1'b1;
    cmd    <= c;
    regIdx <= c.addr[2 +: IDX_W];
    @(posedge aclk);
    start <= 1'b0;
  endtask

  task automatic waitIdle();
    do begin
      @(posedge aclk);
    end while (pending);
  endtask

  task automatic sweepRegs();
    for (int i = 0; i < NUM_REGS; i++) begin
      @(posedge aclk);
      regIdx <= IDX_W'(i);
      @(negedge aclk);
      expectEq($sformatf("regData[%0d]", i), regData, model[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int errsBefore;
    int gap;
    aclk    = 1'b0;
    rstN    = 1'b0;
    start   = 1'b0;
    cmd     = '0;
    regIdx  = '0;
    pending = 1'b0;
    foreach (model[i]) begin
      model[i] = '0;
    end
    if (UUT.NUM_REGS != NUM_REGS || UUT.RESP_DELAY != RESP_DELAY) begin
      $display("testbench register count or delay differs from the top level");
      checkErrors++;
    end
    repeat (5) @(posedge aclk);
    rstN <= 1'b1;
    repeat (3) @(posedge aclk);
    reportTest("test 1 reset state", UUT.props.violations == 0);

    errsBefore = checkErrors;
    pulseStart(writeAgentPkg::writeCmdT'{addr: 32'h0000_000c, data: 32'hcafe_f00d,
                                         strb: 4'hf});
    waitIdle();
    reportTest("test 2 full strobe write", checkErrors == errsBefore);

    errsBefore = checkErrors;
    pulseStart(writeAgentPkg::writeCmdT'{addr: 32'h0000_000c, data: 32'h1234_5678,
                                         strb: 4'b0101});
    waitIdle();
    reportTest("test 3 partial strobe write", checkErrors == errsBefore);

    errsBefore = checkErrors;
    pulseStart(writeAgentPkg::writeCmdT'{addr: axiLitePkg::addrT'((NUM_REGS + 5) * 4),
                                         data: 32'hdead_beef, strb: 4'hf});
    waitIdle();
    sweepRegs();
    reportTest("test 4 out of range write", checkErrors == errsBefore && expErrors == 1);

    errsBefore = checkErrors;
    for (int n = 0; n < 40; n++) begin
      gap = ($random(seed) & 32'hff) % (RESP_DELAY + 7);
      repeat (gap) @(posedge aclk);
      pulseStart(randomCmd());
    end
    waitIdle();
    @(negedge aclk);
    expectEq("writeCount", writeCount, acceptCount);
    sweepRegs();
    $display("random run: %0d starts taken, %0d ignored while busy", acceptCount - 3,
             ignoreCount);
    reportTest("test 5 random commands", checkErrors == errsBefore && ignoreCount > 0);

    repeat (2) @(posedge aclk);
    reportTest("test 6 protocol properties", UUT.props.violations == 0);
    $display("tests passed %0d failed %0d, check errors %0d", testsPassed, testsFailed,
             checkErrors);
    if (testsFailed == 0 && checkErrors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (LIMIT) @(posedge aclk);
    $display("run timed out after %0d cycles without finishing the tests", LIMIT);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== sim.f ====
rtl/axiLitePkg.sv
rtl/writeAgentPkg.sv
rtl/writeDriver.sv
rtl/writeMonitor.sv
rtl/writeMasterAgent.sv
rtl/regFileSlave.sv
rtl/axiLiteWriteTop.sv
tb/axiLiteWrite_properties.sv
tb/axiLiteWriteTb.sv

// ==== Bender.yml ====
package:
  name: axi_lite_write

sources:
  - rtl/axiLitePkg.sv
  - rtl/writeAgentPkg.sv
  - rtl/writeDriver.sv
  - rtl/writeMonitor.sv
  - rtl/writeMasterAgent.sv
  - rtl/regFileSlave.sv
  - rtl/axiLiteWriteTop.sv
  - target: simulation
    files:
      - tb/axiLiteWrite_properties.sv
      - tb/axiLiteWriteTb.sv
